// ==== Makefile ====
SIM = obj_dir/sim_tlb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_tlb -f project.f -Mdir obj_dir -o sim_tlb

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

// ==== common/tlb_pkg.sv ====
package tlb_pkg;

    localparam int tlb_num   = 16;
    localparam int tlb_idx_w = $clog2(tlb_num);

    // legal page size codes, log2 of the page size in bytes
    localparam logic [5:0] ps_4k = 6'd12;
    localparam logic [5:0] ps_2m = 6'd21;

    // crmd style encoding, da = bit 0 and pg = bit 1
    typedef enum logic [1:0] {
        tlb_direct = 2'b01,
        tlb_mapped = 2'b10
    } tlb_mode_e;

    typedef enum logic [1:0] {
        mem_fetch = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_type_e;

    typedef enum logic [2:0] {
        exc_none   = 3'd0,
        exc_refill = 3'd1,
        exc_pif    = 3'd2,
        exc_pil    = 3'd3,
        exc_pis    = 3'd4,
        exc_ppi    = 3'd5,
        exc_pme    = 3'd6
    } tlb_exc_e;

    // one physical half of an entry
    typedef struct packed {
        logic [19:0] pfn;
        logic [1:0]  mat;
        logic [1:0]  plv;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic [5:0]  ps;
        logic        e;
        logic        g;
        tlb_page_t   page0;
        tlb_page_t   page1;
    } tlb_entry_t;

    typedef struct packed {
        logic [31:0] vaddr;
        logic [7:0]  asid;
        logic [1:0]  plv;
        mem_type_e   mem_type;
    } tlb_req_t;

    // index, pfn and mat are zero on a miss or in direct mode
    typedef struct packed {
        logic                 found;
        logic [tlb_idx_w-1:0] index;
        logic [19:0]          pfn;
        logic [1:0]           mat;
        logic [31:0]          paddr;
        tlb_exc_e             exc;
    } tlb_resp_t;

endpackage

// ==== design/tlb_top.sv ====
`timescale 1ns/10ps

module tlb_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  tlb_pkg::tlb_mode_e                   mode,

    // fetch search port
    input  logic                                 fetch_en,
    input  tlb_pkg::tlb_req_t                    fetch_req,
    output logic                                 fetch_valid,
    output tlb_pkg::tlb_resp_t                   fetch_resp,

    // data search port
    input  logic                                 data_en,
    input  tlb_pkg::tlb_req_t                    data_req,
    output logic                                 data_valid,
    output tlb_pkg::tlb_resp_t                   data_resp,

    // write port
    input  logic                                 we,
    input  logic [tlb_pkg::tlb_idx_w-1:0]        w_index,
    input  tlb_pkg::tlb_entry_t                  w_entry,

    // read port
    input  logic [tlb_pkg::tlb_idx_w-1:0]        r_index,
    output tlb_pkg::tlb_entry_t                  r_entry
);

    tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0] all_entries;

    tlb_entry_array u_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .we          (we),
        .w_index     (w_index),
        .w_entry     (w_entry),
        .r_index     (r_index),
        .r_entry     (r_entry),
        .all_entries (all_entries)
    );

    // instruction side
    tlb_lookup u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (fetch_en),
        .mode        (mode),
        .req         (fetch_req),
        .all_entries (all_entries),
        .valid       (fetch_valid),
        .resp        (fetch_resp)
    );

    // load/store side
    tlb_lookup u_data (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (data_en),
        .mode        (mode),
        .req         (data_req),
        .all_entries (all_entries),
        .valid       (data_valid),
        .resp        (data_resp)
    );

endmodule

// ==== project.f ====
common/tlb_pkg.sv
tlb/tlb_entry_array.sv
tlb/tlb_match.sv
tlb/tlb_lookup.sv
design/tlb_top.sv
verif/tlb_asserts.sv
verif/tb_tlb.sv

// ==== tlb/tlb_entry_array.sv ====
`timescale 1ns/10ps

module tlb_entry_array (
    input  logic                                         clk,
    input  logic                                         rst_n,

    // write port
    input  logic                                         we,
    input  logic [tlb_pkg::tlb_idx_w-1:0]                w_index,
    input  tlb_pkg::tlb_entry_t                          w_entry,

    // read port
    input  logic [tlb_pkg::tlb_idx_w-1:0]                r_index,
    output tlb_pkg::tlb_entry_t                          r_entry,

    // every slot at once for the search pipes
    output tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0]   all_entries
);

    // payload of each slot, its e field is shadowed by e_q
    tlb_pkg::tlb_entry_t mem_q [tlb_pkg::tlb_num];

    logic [tlb_pkg::tlb_num-1:0] e_q;

    // only the exist bits come out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_q <= '0;
        end else if (we) begin
            e_q[w_index] <= w_entry.e;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem_q[w_index] <= w_entry;
        end
    end

    // flat view with the live exist bit merged in
    always_comb begin
        for (int i = 0; i < tlb_pkg::tlb_num; i++) begin
            all_entries[i]   = mem_q[i];
            all_entries[i].e = e_q[i];
        end
    end

    // read shares the merged view so e reads back as stored
    assign r_entry = all_entries[r_index];

endmodule

// ==== tlb/tlb_lookup.sv ====
`timescale 1ns/10ps

module tlb_lookup (
    input  logic                                         clk,
    input  logic                                         rst_n,

    input  logic                                         en,
    input  tlb_pkg::tlb_mode_e                           mode,
    input  tlb_pkg::tlb_req_t                            req,
    input  tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0]   all_entries,

    output logic                                         valid,
    output tlb_pkg::tlb_resp_t                           resp
);

    tlb_pkg::tlb_req_t                   req_q;
    tlb_pkg::tlb_mode_e                  mode_q;
    logic                                valid_q;

    logic [tlb_pkg::tlb_num-1:0]         hit_vec;
    logic                                hit;
    logic [tlb_pkg::tlb_idx_w-1:0]       hit_index;
    tlb_pkg::tlb_entry_t                 hit_entry;

    logic                                is_2m;
    logic                                odd;
    tlb_pkg::tlb_page_t                  page;
    logic [31:0]                         paddr_map;
    tlb_pkg::tlb_exc_e                   exc_map;

    // request and mode captured together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q   <= '0;
            mode_q  <= tlb_pkg::tlb_direct;
            valid_q <= 1'b0;
        end else begin
            valid_q <= en;
            if (en) begin
                req_q  <= req;
                mode_q <= mode;
            end
        end
    end

    assign valid = valid_q;

    tlb_match u_match (
        .all_entries (all_entries),
        .vaddr       (req_q.vaddr),
        .asid        (req_q.asid),
        .hit_vec     (hit_vec),
        .hit         (hit),
        .hit_index   (hit_index),
        .hit_entry   (hit_entry)
    );

    // even/odd half selected by the bit just above the page offset
    assign is_2m = (hit_entry.ps == tlb_pkg::ps_2m);
    assign odd   = is_2m ? req_q.vaddr[21] : req_q.vaddr[12];
    assign page  = odd ? hit_entry.page1 : hit_entry.page0;

    assign paddr_map = is_2m ? {page.pfn[19:9], req_q.vaddr[20:0]} :
                               {page.pfn, req_q.vaddr[11:0]};

    // refill > invalid > privilege > modify
    always_comb begin
        if (!hit) begin
            exc_map = tlb_pkg::exc_refill;
        end else if (!page.v) begin
            case (req_q.mem_type)
                tlb_pkg::mem_fetch: exc_map = tlb_pkg::exc_pif;
                tlb_pkg::mem_load:  exc_map = tlb_pkg::exc_pil;
                default:            exc_map = tlb_pkg::exc_pis;
            endcase
        end else if (req_q.plv > page.plv) begin
            exc_map = tlb_pkg::exc_ppi;
        end else if (req_q.mem_type == tlb_pkg::mem_store && !page.d) begin
            exc_map = tlb_pkg::exc_pme;
        end else begin
            exc_map = tlb_pkg::exc_none;
        end
    end

    always_comb begin
        resp = '0;
        if (mode_q == tlb_pkg::tlb_mapped) begin
            resp.found = hit;
            resp.index = hit_index;
            resp.pfn   = page.pfn;
            resp.mat   = page.mat;
            resp.paddr = paddr_map;
            resp.exc   = exc_map;
        end else begin
            // direct mode, identity map
            resp.paddr = req_q.vaddr;
            resp.exc   = tlb_pkg::exc_none;
        end
    end

endmodule

// ==== tlb/tlb_match.sv ====
`timescale 1ns/10ps

module tlb_match (
    input  tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0]   all_entries,
    input  logic [31:0]                                  vaddr,
    input  logic [7:0]                                   asid,

    output logic [tlb_pkg::tlb_num-1:0]                  hit_vec,
    output logic                                         hit,
    output logic [tlb_pkg::tlb_idx_w-1:0]                hit_index,
    output tlb_pkg::tlb_entry_t                          hit_entry
);

    // one comparator per slot
    for (genvar i = 0; i < tlb_pkg::tlb_num; i++) begin : g_cmp
        logic asid_ok;
        logic vpn_ok;

        assign asid_ok = all_entries[i].g || (all_entries[i].asid == asid);

        // 2 MB pages ignore the low vpn2 bits
        assign vpn_ok = (all_entries[i].ps == tlb_pkg::ps_4k) ?
                        (all_entries[i].vpn2 == vaddr[31:13]) :
                        (all_entries[i].vpn2[18:9] == vaddr[31:22]);

        assign hit_vec[i] = all_entries[i].e && asid_ok && vpn_ok;
    end

    assign hit = |hit_vec;

    // lowest index wins on overlap
    always_comb begin
        hit_index = '0;
        hit_entry = '0;
        for (int i = tlb_pkg::tlb_num - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_index = tlb_pkg::tlb_idx_w'(i);
                hit_entry = all_entries[i];
            end
        end
    end

endmodule

// ==== verif/tb_tlb.sv ====
`timescale 1ns/10ps

module tb_tlb;

    typedef struct packed {
        tlb_pkg::tlb_req_t  req;
        tlb_pkg::tlb_resp_t exp;
    } search_t;

    logic                                clk;
    logic                                rst_n;
    tlb_pkg::tlb_mode_e                  mode;
    logic                                fetch_en;
    tlb_pkg::tlb_req_t                   fetch_req;
    logic                                fetch_valid;
    tlb_pkg::tlb_resp_t                  fetch_resp;
    logic                                data_en;
    tlb_pkg::tlb_req_t                   data_req;
    logic                                data_valid;
    tlb_pkg::tlb_resp_t                  data_resp;
    logic                                we;
    logic [tlb_pkg::tlb_idx_w-1:0]       w_index;
    tlb_pkg::tlb_entry_t                 w_entry;
    logic [tlb_pkg::tlb_idx_w-1:0]       r_index;
    tlb_pkg::tlb_entry_t                 r_entry;

    int                  fd;
    logic [31:0]         fld [16];
    search_t             fetch_q [$];
    search_t             data_q [$];
    // entries as written through the write port
    tlb_pkg::tlb_entry_t model_entries [tlb_pkg::tlb_num];

    tlb_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .mode        (mode),
        .fetch_en    (fetch_en),
        .fetch_req   (fetch_req),
        .fetch_valid (fetch_valid),
        .fetch_resp  (fetch_resp),
        .data_en     (data_en),
        .data_req    (data_req),
        .data_valid  (data_valid),
        .data_resp   (data_resp),
        .we          (we),
        .w_index     (w_index),
        .w_entry     (w_entry),
        .r_index     (r_index),
        .r_entry     (r_entry)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #50000;
        abort_run("simulation ran past its time limit");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error at %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
        $display("Something failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    // e_only for slots whose payload was never written
    task automatic check_entry(input tlb_pkg::tlb_entry_t got, input tlb_pkg::tlb_entry_t exp,
                               input logic e_only);
        if (got.e !== exp.e)
            report_mismatch("r_entry.e", 32'(got.e), 32'(exp.e));
        if (!e_only) begin
            if (got.vpn2 !== exp.vpn2)
                report_mismatch("r_entry.vpn2", 32'(got.vpn2), 32'(exp.vpn2));
            if (got.asid !== exp.asid)
                report_mismatch("r_entry.asid", 32'(got.asid), 32'(exp.asid));
            if (got.ps !== exp.ps)
                report_mismatch("r_entry.ps", 32'(got.ps), 32'(exp.ps));
            if (got.g !== exp.g)
                report_mismatch("r_entry.g", 32'(got.g), 32'(exp.g));
            if (got.page0 !== exp.page0)
                report_mismatch("r_entry.page0", 32'(got.page0), 32'(exp.page0));
            if (got.page1 !== exp.page1)
                report_mismatch("r_entry.page1", 32'(got.page1), 32'(exp.page1));
        end
    endtask

    task automatic check_resp(input string port, input tlb_pkg::tlb_resp_t got,
                              input tlb_pkg::tlb_resp_t exp);
        if (got.found !== exp.found)
            report_mismatch({port, "_resp.found"}, 32'(got.found), 32'(exp.found));
        if (got.index !== exp.index)
            report_mismatch({port, "_resp.index"}, 32'(got.index), 32'(exp.index));
        if (got.exc !== exp.exc)
            report_mismatch({port, "_resp.exc"}, 32'(got.exc), 32'(exp.exc));
        if (got.pfn !== exp.pfn)
            report_mismatch({port, "_resp.pfn"}, 32'(got.pfn), 32'(exp.pfn));
        if (got.mat !== exp.mat)
            report_mismatch({port, "_resp.mat"}, 32'(got.mat), 32'(exp.mat));
        // no translation on a refill, so paddr carries nothing
        if (exp.exc != tlb_pkg::exc_refill && got.paddr !== exp.paddr)
            report_mismatch({port, "_resp.paddr"}, got.paddr, exp.paddr);
    endtask

    task automatic read_fields(input int n);
        int code;
        for (int i = 0; i < n; i++) begin
            code = $fscanf(fd, "%h", fld[i]);
            if (code != 1)
                abort_run("malformed line in the data file");
        end
    endtask

    function automatic tlb_pkg::tlb_entry_t entry_from_fields();
        tlb_pkg::tlb_entry_t ent;
        ent.vpn2      = fld[1][18:0];
        ent.asid      = fld[2][7:0];
        ent.ps        = fld[3][5:0];
        ent.e         = fld[4][0];
        ent.g         = fld[5][0];
        ent.page0.pfn = fld[6][19:0];
        ent.page0.mat = fld[7][1:0];
        ent.page0.plv = fld[8][1:0];
        ent.page0.d   = fld[9][0];
        ent.page0.v   = fld[10][0];
        ent.page1.pfn = fld[11][19:0];
        ent.page1.mat = fld[12][1:0];
        ent.page1.plv = fld[13][1:0];
        ent.page1.d   = fld[14][0];
        ent.page1.v   = fld[15][0];
        return ent;
    endfunction

    function automatic search_t search_from_fields();
        search_t srch;
        srch.req.vaddr    = fld[1];
        srch.req.asid     = fld[2][7:0];
        srch.req.plv      = fld[3][1:0];
        srch.req.mem_type = tlb_pkg::mem_type_e'(fld[4][1:0]);
        srch.exp          = '0;
        srch.exp.found    = fld[5][0];
        srch.exp.index    = fld[6][tlb_pkg::tlb_idx_w-1:0];
        srch.exp.paddr    = fld[7];
        srch.exp.exc      = tlb_pkg::tlb_exc_e'(fld[8][2:0]);
        return srch;
    endfunction

    // pfn and mat of the half picked at the ps boundary, zero without a hit
    function automatic tlb_pkg::tlb_resp_t expected_resp(input search_t srch);
        tlb_pkg::tlb_resp_t  exp;
        tlb_pkg::tlb_entry_t ent;
        logic                odd;
        exp = srch.exp;
        if (exp.found) begin
            ent = model_entries[exp.index];
            if (ent.ps == tlb_pkg::ps_2m)
                odd = srch.req.vaddr[21];
            else
                odd = srch.req.vaddr[12];
            exp.pfn = odd ? ent.page1.pfn : ent.page0.pfn;
            exp.mat = odd ? ent.page1.mat : ent.page0.mat;
        end
        return exp;
    endfunction

    task automatic wait_valid(input logic data_port);
        int cycles;
        cycles = 0;
        while (!(data_port ? data_valid : fetch_valid) && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        if (!(data_port ? data_valid : fetch_valid)) begin
            if (data_port)
                abort_run("data port never raised valid");
            else
                abort_run("fetch port never raised valid");
        end
    endtask

    // both ports issue in the same cycles, one request per cycle
    task automatic run_searches();
        int nf;
        int nd;
        int n;
        nf = fetch_q.size();
        nd = data_q.size();
        n  = (nf > nd) ? nf : nd;
        for (int k = 0; k <= n; k++) begin
            @(negedge clk);
            if (k > 0 && k <= nf) begin
                wait_valid(1'b0);
                check_resp("fetch", fetch_resp, expected_resp(fetch_q[k-1]));
            end
            if (k > 0 && k <= nd) begin
                wait_valid(1'b1);
                check_resp("data", data_resp, expected_resp(data_q[k-1]));
            end
            fetch_en = (k < nf);
            data_en  = (k < nd);
            if (k < nf)
                fetch_req = fetch_q[k].req;
            if (k < nd)
                data_req = data_q[k].req;
        end
        fetch_q.delete();
        data_q.delete();
    endtask

    initial begin : main
        logic [7:0]       cmd;
        logic [8*128-1:0] rest;
        int               code;
        logic             done;

        rst_n     = 1'b0;
        mode      = tlb_pkg::tlb_mapped;
        fetch_en  = 1'b0;
        fetch_req = '0;
        data_en   = 1'b0;
        data_req  = '0;
        we        = 1'b0;
        w_index   = '0;
        w_entry   = '0;
        r_index   = '0;
        done      = 1'b0;

        fd = $fopen("verif/tlb_testdata.txt", "r");
        if (fd == 0)
            abort_run("cannot open verif/tlb_testdata.txt");

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        while (!done) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": code = $fgets(rest, fd);
                    "M": begin
                        read_fields(1);
                        mode = tlb_pkg::tlb_mode_e'(fld[0][1:0]);
                    end
                    "W": begin
                        read_fields(16);
                        we      = 1'b1;
                        w_index = fld[0][tlb_pkg::tlb_idx_w-1:0];
                        w_entry = entry_from_fields();
                        model_entries[w_index] = w_entry;
                        @(negedge clk);
                        we = 1'b0;
                    end
                    "R": begin
                        read_fields(16);
                        r_index = fld[0][tlb_pkg::tlb_idx_w-1:0];
                        @(negedge clk);
                        check_entry(r_entry, entry_from_fields(), 1'b0);
                    end
                    "X": begin
                        read_fields(1);
                        r_index = fld[0][tlb_pkg::tlb_idx_w-1:0];
                        @(negedge clk);
                        check_entry(r_entry, '0, 1'b1);
                    end
                    "S": begin
                        read_fields(9);
                        if (fld[0][0])
                            data_q.push_back(search_from_fields());
                        else
                            fetch_q.push_back(search_from_fields());
                    end
                    "G": run_searches();
                    default: abort_run("unknown command in the data file");
                endcase
            end
        end
        $fclose(fd);

        if (fetch_q.size() != 0 || data_q.size() != 0) begin
            abort_run("searches left queued at the end of the data file");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== verif/tlb_asserts.sv ====
`timescale 1ns/10ps

module tlb_asserts (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          valid,
    input  tlb_pkg::tlb_mode_e            mode_q,
    input  logic [tlb_pkg::tlb_num-1:0]   hit_vec,
    input  tlb_pkg::tlb_resp_t            resp
);

    // fixed one cycle search latency
    a_valid_follows_en: assert property (@(posedge clk) disable iff (!rst_n)
        valid == $past(en))
        else $error("valid did not follow en by one cycle");

    a_valid_in_reset: assert property (@(posedge clk) !rst_n |-> !valid)
        else $error("valid high during reset");

    // entries loaded here never overlap
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> $onehot0(hit_vec))
        else $error("more than one entry hit");

    a_direct_resp: assert property (@(posedge clk) disable iff (!rst_n)
        (valid && mode_q == tlb_pkg::tlb_direct) |->
        (!resp.found && resp.exc == tlb_pkg::exc_none))
        else $error("direct mode response reports a hit or an exception");

endmodule

bind tlb_lookup tlb_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (en),
    .valid   (valid),
    .mode_q  (mode_q),
    .hit_vec (hit_vec),
    .resp    (resp)
);

// ==== verif/tlb_testdata.txt ====
# W idx vpn2 asid ps e g pfn0 mat0 plv0 d0 v0 pfn1 mat1 plv1 d1 v1, R same with expected fields
# S port(0 fetch 1 data) vaddr asid plv mtype found index paddr exc, M mode, X idx empty, G run
X 0
X 7
M 2
W 0 00400 05 0c 1 0 12345 1 3 1 1 0abcd 1 0 0 1
W 5 20055 33 15 1 1 801ff 2 3 1 1 90000 2 3 1 0
W 9 7ffff 01 0c 1 0 00111 0 0 1 1 00222 3 2 1 1
W f 00010 05 0c 0 1 0dead 0 3 1 1 0beef 0 3 1 1
R 0 00400 05 0c 1 0 12345 1 3 1 1 0abcd 1 0 0 1
R 5 20055 33 15 1 1 801ff 2 3 1 1 90000 2 3 1 0
R 9 7ffff 01 0c 1 0 00111 0 0 1 1 00222 3 2 1 1
R f 00010 05 0c 0 1 0dead 0 3 1 1 0beef 0 3 1 1
X 7
# hits on 4 KB and 2 MB pages, even and odd halves
S 0 00800123 05 3 0 1 0 12345123 0
S 0 00801abc 05 0 0 1 0 0abcdabc 0
S 0 ffffe010 01 0 0 1 9 00111010 0
S 1 40012345 99 0 2 1 5 80012345 0
S 1 00801abc 05 0 1 1 0 0abcdabc 0
S 1 fffff800 01 2 2 1 9 00222800 0
G
# misses and exception priority
S 0 00800123 06 0 0 0 0 00000000 1
S 0 00020123 05 0 0 0 0 00000000 1
S 0 ffffe010 02 0 0 0 0 00000000 1
S 0 40234567 99 0 0 1 5 90034567 2
S 0 00801abc 05 3 0 1 0 0abcdabc 5
S 1 40234567 99 0 1 1 5 90034567 3
S 1 40234567 99 0 2 1 5 90034567 4
S 1 00801abc 05 0 2 1 0 0abcdabc 6
S 1 00801abc 05 3 2 1 0 0abcdabc 5
G
# rewrite between two searches of one address
S 0 00800123 05 3 0 1 0 12345123 0
G
W 0 00400 05 0c 1 0 55555 1 3 1 1 0abcd 1 0 0 1
S 0 00800123 05 3 0 1 0 55555123 0
G
R 0 00400 05 0c 1 0 55555 1 3 1 1 0abcd 1 0 0 1
# direct mode on addresses that would hit
M 1
S 0 00800123 05 3 0 0 0 00800123 0
S 1 40234567 99 0 2 0 0 40234567 0
G
